// File: design/byte_lane_ram.sv
//////////////////////////////
// Dual-port byte-addressed RAM
// Byte-lane write port, registered data read port
// and a registered instruction port that reads every
// cycle. Offsets and window flags come from the
// address decoders in the top level.
//////////////////////////////

`timescale 1ns/1ps

`include "sim_mem_defines.svh"

module byte_lane_ram import sim_mem_pkg::*; (
    input  logic        clock,
    input  logic        rst,                        // Sync, active low

    // Write port
    input  mem_offset_t wr_offset,                  // Byte offset of the word
    input  logic        wr_ok,                      // In window, not console
    input  byte_en_t    wr_be,                      // Lane enables
    input  word_t       wr_data,                    // Lane-aligned data

    // Data read port
    input  logic        rd_en,                      // Read request
    input  mem_offset_t rd_offset,
    input  logic        rd_ok,                      // Read address in window
    output word_t       data_read,                  // One cycle after rd_en

    // Instruction port
    input  mem_offset_t if_offset,
    input  logic        if_ok,                      // Fetch address in window
    output word_t       instruction                 // One cycle after address
);

    // 2-state storage, every byte is zero at time 0
    bit [7:0] mem [`MEM_BYTES];

    logic wr_req;                                   // Write accepted this edge
    logic rd_take;                                  // Data read accepted
    logic if_take;                                  // Fetch accepted

    // Little-endian word starting at base
    function automatic word_t read_word(input mem_offset_t base);
        word_t w;
        w = '0;
        for (int lane = 0; lane < WORD_BYTES; lane++) begin
            w[8*lane +: 8] = mem[base + mem_offset_t'(lane)];  // Lane 0 at lowest address
        end
        return w;
    endfunction

    assign wr_req  = wr_ok && (wr_be != '0);        // Idle when no lane enabled
    assign rd_take = rd_en && rd_ok;
    assign if_take = if_ok;                         // Fetch runs every cycle

    // Write port
    // Disabled lanes keep their bytes
    always_ff @(posedge clock) begin
        if (wr_req) begin
            for (int lane = 0; lane < WORD_BYTES; lane++) begin
                if (wr_be[lane]) begin
                    mem[wr_offset + mem_offset_t'(lane)] <= wr_data[8*lane +: 8];
                end
            end
        end
    end

    // Data read register
    // Sampled before the write above lands, so old data on a collision
    always_ff @(posedge clock) begin
        if (!rst) begin
            data_read <= '0;
        end else if (rd_take) begin
            data_read <= read_word(rd_offset);
        end                                         // Otherwise hold
    end

    // Instruction register
    // Out-of-window fetch keeps the last word
    always_ff @(posedge clock) begin
        if (!rst) begin
            instruction <= '0;
        end else if (if_take) begin
            instruction <= read_word(if_offset);
        end
    end

endmodule

// File: design/console_port.sv
//////////////////////////////
// Console output register
// Captures the low byte of a write to the console
// address and strobes console_valid for one cycle.
// Stands in for a memory-mapped character device.
//////////////////////////////

`timescale 1ns/1ps

module console_port import sim_mem_pkg::*; (
    input  logic  clock,
    input  logic  rst,                              // Sync, active low
    input  logic  hit,                              // Write address is the console
    input  logic  be0,                              // Lane 0 enabled
    input  byte_t wr_byte,                          // Low data byte
    output logic  console_valid,                    // One-cycle strobe
    output byte_t console_char                      // Character for the strobe
);

    logic take;                                     // Character accepted this edge

    // Only lane 0 carries the character
    assign take = hit && be0;

    // Strobe follows each accepted write by one cycle
    always_ff @(posedge clock) begin
        if (!rst) begin
            console_valid <= 1'b0;
        end else begin
            console_valid <= take;                  // Back-to-back writes stay high
        end
    end

    // Character register
    // Holds the last character between strobes
    always_ff @(posedge clock) begin
        if (!rst) begin
            console_char <= '0;
        end else if (take) begin
            console_char <= wr_byte;
        end
    end

endmodule

// File: design/mem_window_decode.sv
//////////////////////////////
// Bus address to RAM offset decode
// Subtracts the window base and flags whether a
// full word fits inside the RAM. Instantiated once
// per access port in the top level.
//////////////////////////////

`timescale 1ns/1ps

`include "sim_mem_defines.svh"

module mem_window_decode import sim_mem_pkg::*; (
    input  word_t       address,                    // Bus byte address
    output mem_offset_t offset,                     // Byte offset into RAM
    output logic        in_window                   // Whole word lies inside RAM
);

    // Highest offset that still leaves room for a full word
    localparam mem_offset_t LAST_WORD = mem_offset_t'(`MEM_BYTES - WORD_BYTES);

    word_t rel_addr;                                // Distance above the base
    logic  high_clear;                              // Nothing above the offset width
    logic  word_fits;                               // No run past the array end

    // Addresses below the base wrap around and set high bits
    assign rel_addr = address - `MEM_BASE_ADDR;     // Modulo 2^32

    // Low bits index the byte array
    assign offset = rel_addr[`MEM_ADDR_BITS-1:0];

    // Window checks
    assign high_clear = (rel_addr[31:`MEM_ADDR_BITS] == '0);
    assign word_fits  = (offset <= LAST_WORD);      // Last three bytes excluded

    assign in_window = high_clear && word_fits;     // Both must hold

endmodule

// File: design/sim_mem_defines.svh
//////////////////////////////
// Memory map of the simulation RAM
// Base of the RAM window, offset width, RAM size
// and the console output word address.
// Include before the package and in any module
// that decodes bus addresses.
//////////////////////////////

`ifndef SIM_MEM_DEFINES_SVH
`define SIM_MEM_DEFINES_SVH

// RAM window placement
`define MEM_BASE_ADDR 32'h0000_0000                 // First byte address mapped to RAM

// Offset into the byte array
`define MEM_ADDR_BITS 16                            // 64 KiB window

// Bytes held by the array
`define MEM_BYTES (1 << `MEM_ADDR_BITS)              // Follows the offset width

// Memory-mapped character output, never stored in RAM
`define CONSOLE_ADDR 32'h8000_1000                  // Word address of the console

`endif

// File: design/sim_mem_pkg.sv
//////////////////////////////
// Shared types of the simulation memory
// Bus word, RAM offset, byte enables and the
// data port write request. Import with a
// wildcard in the module header.
//////////////////////////////

`include "sim_mem_defines.svh"

package sim_mem_pkg;

    // Byte lanes per bus word
    localparam int WORD_BYTES = 4;                  // RV32 word

    // 32-bit bus word, carries addresses and data
    typedef logic [31:0] word_t;

    // One byte lane
    typedef logic [7:0] byte_t;                     // Console character too

    // Byte offset into the RAM array
    typedef logic [`MEM_ADDR_BITS-1:0] mem_offset_t;

    // One enable per lane
    // Bit 0 covers bits 7:0, bit 3 covers bits 31:24
    typedef logic [WORD_BYTES-1:0] byte_en_t;

    // Data port write request
    // Any set enable requests a write
    typedef struct packed {
        word_t    address;                          // Byte address on the bus
        byte_en_t byte_en;                          // Lane enables, zero means idle
        word_t    data;                             // Lane-aligned store data
    } data_write_t;

endpackage

// File: design/sim_memory_top.sv
//////////////////////////////
// Simulation memory subsystem top
// Instruction fetch port, data read/write port and
// console output. Decodes each port address into the
// RAM window and keeps console writes out of the RAM.
//////////////////////////////

`timescale 1ns/1ps

`include "sim_mem_defines.svh"

module sim_memory_top import sim_mem_pkg::*; (
    input  logic        clock,
    input  logic        rst,                        // Sync, active low

    // Instruction port
    input  word_t       i_address,                  // Fetch byte address
    output word_t       instruction,

    // Data port
    input  data_write_t data_wr,                    // Address, enables, data
    input  logic        read_enable,
    input  word_t       read_address,
    output word_t       data_read,

    // Console
    output logic        console_valid,
    output byte_t       console_char
);

    mem_offset_t if_offset;                         // Fetch offset
    mem_offset_t rd_offset;                         // Data read offset
    mem_offset_t wr_offset;                         // Data write offset
    logic        if_ok;
    logic        rd_ok;
    logic        wr_in_window;
    logic        console_hit;                       // Write targets the console
    logic        wr_ok;                             // Write may reach the RAM

    // One decoder per port address
    mem_window_decode u_if_dec (
        .address   (i_address),
        .offset    (if_offset),
        .in_window (if_ok)
    );

    mem_window_decode u_rd_dec (
        .address   (read_address),
        .offset    (rd_offset),
        .in_window (rd_ok)
    );

    mem_window_decode u_wr_dec (
        .address   (data_wr.address),
        .offset    (wr_offset),
        .in_window (wr_in_window)
    );

    // Single console compare shared by RAM and console
    assign console_hit = (data_wr.address == `CONSOLE_ADDR);
    assign wr_ok       = wr_in_window && !console_hit;  // Console never lands in RAM

    byte_lane_ram u_ram (
        .clock       (clock),
        .rst         (rst),
        .wr_offset   (wr_offset),
        .wr_ok       (wr_ok),
        .wr_be       (data_wr.byte_en),
        .wr_data     (data_wr.data),
        .rd_en       (read_enable),
        .rd_offset   (rd_offset),
        .rd_ok       (rd_ok),
        .data_read   (data_read),
        .if_offset   (if_offset),
        .if_ok       (if_ok),
        .instruction (instruction)
    );

    console_port u_console (
        .clock         (clock),
        .rst           (rst),
        .hit           (console_hit),
        .be0           (data_wr.byte_en[0]),
        .wr_byte       (data_wr.data[7:0]),         // Low lane only
        .console_valid (console_valid),
        .console_char  (console_char)
    );

endmodule

// File: sources.f
+incdir+design
design/sim_mem_pkg.sv
design/mem_window_decode.sv
design/byte_lane_ram.sv
design/console_port.sv
design/sim_memory_top.sv
tb/tb_clock_gen.sv
tb/sim_memory_assertions.sv
tb/sim_memory_tb.sv

// File: tb/sim_memory_assertions.sv
//////////////////////////////
// Protocol assertions for the memory top
// Console strobe shape and reset values.
// Bound into sim_memory_top, failures are
// counted for the testbench verdict.
//////////////////////////////

`timescale 1ns/1ps

`include "sim_mem_defines.svh"

module sim_memory_assertions import sim_mem_pkg::*; (
    input logic        clock,
    input logic        rst,
    input data_write_t data_wr,
    input logic        console_valid,
    input word_t       instruction,
    input word_t       data_read
);

    int   fail_count;                               // Read by the testbench
    logic console_wr;                               // Character write this cycle

    assign console_wr = (data_wr.address == `CONSOLE_ADDR) && data_wr.byte_en[0];

    // Two strobes in a row need two writes in a row
    a_strobe_pair: assert property (@(posedge clock) disable iff (!rst)
        (console_valid && $past(console_valid)) |-> ($past(console_wr) && $past(console_wr, 2)))
        else begin
            $error("console_valid high twice without two console writes");
            fail_count++;
        end

    // Strobe only after a console write
    a_strobe_cause: assert property (@(posedge clock) disable iff (!rst)
        console_valid |-> $past(console_wr))
        else begin
            $error("console_valid high without a console write");
            fail_count++;
        end

    // Output registers cleared under reset
    a_reset_clear: assert property (@(posedge clock)
        !rst |=> (instruction == '0 && data_read == '0))
        else begin
            $error("instruction or data_read not cleared by reset");
            fail_count++;
        end

endmodule

bind sim_memory_top sim_memory_assertions u_assert (
    .clock         (clock),
    .rst           (rst),
    .data_wr       (data_wr),
    .console_valid (console_valid),
    .instruction   (instruction),
    .data_read     (data_read)
);

// File: tb/sim_memory_tb.sv
//////////////////////////////
// Testbench of the simulation memory
// Table of write, read, fetch and console steps,
// checked against a byte-array model of the RAM.
// Prints one line per step and a closing verdict.
//////////////////////////////

`timescale 1ns/1ps

`include "sim_mem_defines.svh"

module sim_memory_tb import sim_mem_pkg::*; ;

    localparam int   CLK_PERIOD = 100;              // ns
    localparam word_t BASE      = `MEM_BASE_ADDR;
    localparam word_t IDLE_ADDR = `MEM_BASE_ADDR - 4;  // Always outside the window

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_FETCH, OP_CONSOLE, OP_RDWR} op_t;

    typedef struct packed {
        logic [2:0] group;                          // Behavior under test
        op_t        op;
        word_t      addr;
        byte_en_t   be;
        word_t      data;
    } step_t;

    logic        clock;
    logic        rst;
    word_t       i_address;
    word_t       instruction;
    data_write_t data_wr;
    logic        read_enable;
    word_t       read_address;
    word_t       data_read;
    logic        console_valid;
    byte_t       console_char;

    step_t       table_q[$];                        // Stimulus table
    bit          table_ready;
    bit [7:0]    model_mem [`MEM_BYTES];            // Reference RAM, zero at start
    word_t       exp_data_read;
    word_t       exp_instr;
    byte_t       exp_char;
    int          err_count;
    int          steps_run;
    int          steps_failed;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) u_clk (
        .clock (clock),
        .rst   (rst)
    );

    sim_memory_top u_dut (
        .clock         (clock),
        .rst           (rst),
        .i_address     (i_address),
        .instruction   (instruction),
        .data_wr       (data_wr),
        .read_enable   (read_enable),
        .read_address  (read_address),
        .data_read     (data_read),
        .console_valid (console_valid),
        .console_char  (console_char)
    );

    // Full word fits between base and array end
    function automatic bit model_in_window(input word_t addr);
        word_t rel;
        rel = addr - BASE;                          // Below base wraps high
        return rel <= word_t'(`MEM_BYTES - 4);
    endfunction

    // Little-endian word from the model
    function automatic word_t model_word(input word_t addr);
        word_t rel;
        word_t w;
        rel = addr - BASE;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = model_mem[rel + i];
        end
        return w;
    endfunction

    task automatic model_store(input word_t addr, input byte_en_t be, input word_t data);
        word_t rel;
        rel = addr - BASE;
        if (!model_in_window(addr) || addr == `CONSOLE_ADDR || be == '0) begin
            return;                                 // Memory untouched
        end
        for (int i = 0; i < 4; i++) begin
            if (be[i]) model_mem[rel + i] = data[8*i +: 8];
        end
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic add_step(input int grp, input op_t op, input word_t addr,
                            input byte_en_t be, input word_t data);
        table_q.push_back('{group: grp[2:0], op: op, addr: addr, be: be, data: data});
    endtask

    function automatic word_t rand_addr();
        return BASE + (($urandom % (`MEM_BYTES / 4)) << 2);  // Aligned, inside window
    endfunction

    task automatic build_table();
        word_t r_addr;
        word_t con_ram;
        r_addr  = rand_addr();
        con_ram = BASE + ((`CONSOLE_ADDR - BASE) & (`MEM_BYTES - 1));  // Shadowed RAM word
        // Byte-lane merge
        add_step(2, OP_WRITE, BASE + 32'h100, 4'hF, 32'h1122_3344);
        add_step(2, OP_WRITE, BASE + 32'h100, 4'h1, 32'h0000_00AA);
        add_step(2, OP_WRITE, BASE + 32'h100, 4'h4, 32'h00BB_0000);
        add_step(2, OP_WRITE, BASE + 32'h100, 4'hC, 32'hCCDD_0000);  // Upper half
        add_step(2, OP_READ,  BASE + 32'h100, 4'h0, 32'h0);
        add_step(2, OP_WRITE, BASE + 32'h104, 4'h3, $urandom);
        add_step(2, OP_READ,  BASE + 32'h104, 4'h0, 32'h0);
        // Instruction port
        add_step(3, OP_WRITE, BASE + 32'h200, 4'hF, $urandom);
        add_step(3, OP_WRITE, BASE + 32'h204, 4'hF, $urandom);
        add_step(3, OP_FETCH, BASE + 32'h200, 4'h0, 32'h0);
        add_step(3, OP_FETCH, BASE + 32'h204, 4'h0, 32'h0);
        add_step(3, OP_WRITE, r_addr, 4'hF, $urandom);
        add_step(3, OP_FETCH, r_addr, 4'h0, 32'h0);
        add_step(3, OP_READ,  r_addr, 4'h0, 32'h0);
        // Window limits
        add_step(4, OP_WRITE, BASE + `MEM_BYTES - 4, 4'hF, $urandom);  // Last full word
        add_step(4, OP_WRITE, BASE, 4'hF, $urandom);
        add_step(4, OP_WRITE, BASE + 32'h300, 4'hF, $urandom);
        add_step(4, OP_WRITE, BASE - 4, 4'hF, $urandom);                // Below base
        add_step(4, OP_WRITE, BASE + `MEM_BYTES - 2, 4'hF, $urandom);   // Runs off the end
        add_step(4, OP_WRITE, BASE + `MEM_BYTES, 4'hF, $urandom);       // Above the window
        add_step(4, OP_WRITE, BASE + 32'h300, 4'h0, $urandom);          // No lanes
        add_step(4, OP_READ,  BASE + `MEM_BYTES - 4, 4'h0, 32'h0);
        add_step(4, OP_READ,  BASE, 4'h0, 32'h0);
        add_step(4, OP_READ,  BASE + 32'h300, 4'h0, 32'h0);
        add_step(4, OP_READ,  BASE + `MEM_BYTES - 2, 4'h0, 32'h0);      // Holds data_read
        add_step(4, OP_FETCH, BASE - 4, 4'h0, 32'h0);                   // Holds instruction
        // Console
        add_step(5, OP_WRITE,   con_ram, 4'hF, $urandom);
        add_step(5, OP_CONSOLE, `CONSOLE_ADDR, 4'h1, $urandom);
        add_step(5, OP_CONSOLE, `CONSOLE_ADDR, 4'hF, 32'h0000_0041);
        add_step(5, OP_CONSOLE, `CONSOLE_ADDR, 4'h2, $urandom);         // No lane 0, no strobe
        add_step(5, OP_READ,    con_ram, 4'h0, 32'h0);
        // Read during write
        add_step(6, OP_WRITE, BASE + 32'h400, 4'hF, $urandom);
        add_step(6, OP_RDWR,  BASE + 32'h400, 4'hF, $urandom);
        add_step(6, OP_READ,  BASE + 32'h400, 4'h0, 32'h0);
        add_step(6, OP_RDWR,  BASE + 32'h400, 4'h2, $urandom);
        add_step(6, OP_READ,  BASE + 32'h400, 4'h0, 32'h0);
    endtask

    task automatic drive_idle();
        data_wr      <= '{address: 32'h0, byte_en: 4'h0, data: 32'h0};
        read_enable  <= 1'b0;
        read_address <= 32'h0;
        i_address    <= IDLE_ADDR;                  // Instruction holds
    endtask

    task automatic run_step(input int idx, input step_t s);
        bit is_con;
        bit is_wr;
        int errs_at_start;
        errs_at_start = err_count;
        is_wr  = s.op inside {OP_WRITE, OP_CONSOLE, OP_RDWR};
        is_con = is_wr && s.addr == `CONSOLE_ADDR && s.be[0];
        @(posedge clock);
        if (is_wr) data_wr <= '{address: s.addr, byte_en: s.be, data: s.data};
        if (s.op == OP_READ || s.op == OP_RDWR) begin
            read_enable  <= 1'b1;
            read_address <= s.addr;
        end
        if (s.op == OP_FETCH) i_address <= s.addr;
        // Expected reads use the model before this write
        if ((s.op == OP_READ || s.op == OP_RDWR) && model_in_window(s.addr)) begin
            exp_data_read = model_word(s.addr);
        end
        if (s.op == OP_FETCH && model_in_window(s.addr)) exp_instr = model_word(s.addr);
        if (is_wr) model_store(s.addr, s.be, s.data);
        if (is_con) exp_char = s.data[7:0];
        @(posedge clock);                           // DUT takes the request here
        drive_idle();
        @(negedge clock);
        check_value("data_read", data_read, exp_data_read);
        check_value("instruction", instruction, exp_instr);
        check_value("console_valid", word_t'(console_valid), word_t'(is_con));
        check_value("console_char", word_t'(console_char), word_t'(exp_char));
        if (s.op == OP_CONSOLE) begin
            @(negedge clock);                       // Strobe lasts one cycle
            check_value("console_valid", word_t'(console_valid), 32'h0);
        end
        steps_run++;
        if (err_count != errs_at_start) steps_failed++;
        $display("Step %0d behavior %0d %s addr 0x%08h be 0x%h: %s", idx, s.group,
                 s.op.name(), s.addr, s.be, (err_count == errs_at_start) ? "ok" : "failed");
    endtask

    task automatic check_reset_values();
        int errs_at_start;
        errs_at_start = err_count;
        check_value("instruction", instruction, 32'h0);
        check_value("data_read", data_read, 32'h0);
        check_value("console_valid", word_t'(console_valid), 32'h0);
        check_value("console_char", word_t'(console_char), 32'h0);
        steps_run++;
        if (err_count != errs_at_start) steps_failed++;
        $display("Reset values: %s", (err_count == errs_at_start) ? "ok" : "failed");
    endtask

    // Watchdog sized from the table length
    initial begin : watchdog
        wait (table_ready);
        #((table_q.size() * 4 + 20) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock periods",
                 table_q.size() * 4 + 20);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main_seq
        i_address    = IDLE_ADDR;
        data_wr      = '{address: 32'h0, byte_en: 4'h0, data: 32'h0};
        read_enable  = 1'b0;
        read_address = 32'h0;
        exp_data_read = '0;
        exp_instr     = '0;
        exp_char      = '0;
        void'($urandom(32'h1939));                  // One seed for the run
        build_table();
        table_ready = 1'b1;
        wait (rst === 1'b1);
        @(negedge clock);
        check_reset_values();
        foreach (table_q[i]) begin
            run_step(i, table_q[i]);
        end
        $display("Done: %0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion errors",
                 steps_run, steps_run - steps_failed, steps_failed, err_count,
                 u_dut.u_assert.fail_count);
        if (err_count == 0 && steps_failed == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
//////////////////////////////
// Testbench clock and reset source
// Free-running clock, reset held low for the
// first RESET_CYCLES rising edges.
//////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,               // ns
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic rst                                // Active low
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;       // 50% duty
    end

    initial begin
        rst = 1'b0;                                 // Asserted from time 0
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b1;                                // Released on an edge
    end

endmodule
